/* design/calc_pkg.sv */
package calc_pkg;

  localparam int data_width       = 32;
  localparam int reg_addr_width   = 5;
  localparam int stage_els        = 4;
  localparam int int_inject_stage = 1;
  localparam int mul_inject_stage = 3;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    e_op_add,
    e_op_sub,
    e_op_and,
    e_op_or,
    e_op_xor,
    e_op_sll,
    e_op_srl,
    e_op_slt,
    e_op_mul
  } op_e;

  // Operand values are read from the register file before dispatch
  typedef struct packed {
    logic      v;
    op_e       opcode;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1;
    data_t     rs2;
  } dispatch_pkt_s;

  typedef struct packed {
    logic      v;
    op_e       opcode;
    reg_addr_t rd_addr;
    logic      irf_w_v;
    logic      pipe_mul_v;
  } stage_info_s;

  typedef struct packed {
    logic      iwb_v;
    reg_addr_t rd_addr;
  } fwd_slice_s;

  typedef struct packed {
    logic      v;
    logic      int_iwb_v;
    logic      mul_iwb_v;
    reg_addr_t rd_addr;
  } dep_status_s;

  typedef dep_status_s [stage_els-1:0] calc_status_s;

  typedef struct packed {
    logic      rd_w_v;
    reg_addr_t rd_addr;
    data_t     rd_data;
  } wb_pkt_s;

endpackage

/* design/calc_pipe_int.sv */
`timescale 1ns/1ps

module calc_pipe_int
  (
    input  calc_pkg::dispatch_pkt_s reservation_i,
    output calc_pkg::data_t         data_o
  );

  calc_pkg::data_t rs1;
  calc_pkg::data_t rs2;

  assign rs1 = reservation_i.rs1;
  assign rs2 = reservation_i.rs2;

  always_comb
  begin
    case (reservation_i.opcode)
      calc_pkg::e_op_add: data_o = rs1 + rs2;
      calc_pkg::e_op_sub: data_o = rs1 - rs2;
      calc_pkg::e_op_and: data_o = rs1 & rs2;
      calc_pkg::e_op_or:  data_o = rs1 | rs2;
      calc_pkg::e_op_xor: data_o = rs1 ^ rs2;
      // Shift amount is the low five bits of rs2
      calc_pkg::e_op_sll: data_o = rs1 << rs2[4:0];
      calc_pkg::e_op_srl: data_o = rs1 >> rs2[4:0];
      calc_pkg::e_op_slt: data_o = calc_pkg::data_t'($signed(rs1) < $signed(rs2));
      default:            data_o = '0;
    endcase
  end

endmodule

/* design/calc_pipe_mul.sv */
`timescale 1ns/1ps

module calc_pipe_mul
  (
    input  logic                    clk_i,
    input  calc_pkg::dispatch_pkt_s reservation_i,
    output calc_pkg::data_t         data_o
  );

  calc_pkg::data_t rs1_r;
  calc_pkg::data_t rs2_r;
  calc_pkg::data_t product_r;

  // Operands are captured one cycle after the reservation
  always_ff @(posedge clk_i)
  begin
    rs1_r <= reservation_i.rs1;
    rs2_r <= reservation_i.rs2;
  end

  // Only the low word of the product is kept
  always_ff @(posedge clk_i)
  begin
    product_r <= rs1_r * rs2_r;
  end

  assign data_o = product_r;

endmodule

/* design/calc_completion.sv */
`timescale 1ns/1ps

module calc_completion
  (
    input  logic                                   clk_i,
    input  calc_pkg::data_t                        int_data_i,
    input  calc_pkg::data_t                        mul_data_i,
    input  logic                                   int_done_i,
    input  logic                                   mul_done_i,
    output calc_pkg::data_t [calc_pkg::stage_els:1] fwd_data_o,
    output calc_pkg::data_t                        wb_data_o
  );

  calc_pkg::data_t [calc_pkg::stage_els:0]   comp_n;
  calc_pkg::data_t [calc_pkg::stage_els-1:0] comp_r;

  // Static latencies keep the two injection points from colliding
  always_comb
  begin
    comp_n[0] = '0;
    for (int i = 1; i <= calc_pkg::stage_els; i++)
    begin
      comp_n[i] = comp_r[i-1];
      if ((i == calc_pkg::int_inject_stage) && int_done_i)
      begin
        comp_n[i] = int_data_i;
      end
      if ((i == calc_pkg::mul_inject_stage) && mul_done_i)
      begin
        comp_n[i] = mul_data_i;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n[calc_pkg::stage_els-1:0];
  end

  assign fwd_data_o = comp_n[calc_pkg::stage_els:1];
  // Last registered stage is the one being written back
  assign wb_data_o  = comp_r[calc_pkg::stage_els-1];

endmodule

/* design/calc_operand_stage.sv */
`timescale 1ns/1ps

module calc_operand_stage
  (
    input  logic                                        clk_i,
    input  calc_pkg::dispatch_pkt_s                     dispatch_pkt_i,
    input  calc_pkg::fwd_slice_s [calc_pkg::stage_els:1] fwd_i,
    input  calc_pkg::data_t      [calc_pkg::stage_els:1] fwd_data_i,
    output calc_pkg::dispatch_pkt_s                     reservation_o
  );

  calc_pkg::dispatch_pkt_s reservation_n;

  // Nearest matching stage wins, so scan from the far end and overwrite
  function automatic calc_pkg::data_t bypass_sel
    (
      input calc_pkg::reg_addr_t                         addr,
      input calc_pkg::data_t                             id_data,
      input calc_pkg::fwd_slice_s [calc_pkg::stage_els:1] fwd,
      input calc_pkg::data_t      [calc_pkg::stage_els:1] fwd_data
    );
    calc_pkg::data_t sel;
    sel = id_data;
    for (int i = calc_pkg::stage_els; i >= 1; i--)
    begin
      if (fwd[i].iwb_v && (fwd[i].rd_addr == addr))
      begin
        sel = fwd_data[i];
      end
    end
    return sel;
  endfunction

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass_sel(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1,
                                   fwd_i, fwd_data_i);
    reservation_n.rs2 = bypass_sel(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2,
                                   fwd_i, fwd_data_i);
  end

  always_ff @(posedge clk_i)
  begin
    reservation_o <= reservation_n;
  end

endmodule

/* design/calc_ctrl.sv */
`timescale 1ns/1ps

module calc_ctrl
  (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  calc_pkg::dispatch_pkt_s                     dispatch_pkt_i,
    input  logic                                        flush_i,
    output calc_pkg::fwd_slice_s [calc_pkg::stage_els:1] fwd_o,
    output logic                                        int_done_o,
    output logic                                        mul_done_o,
    output calc_pkg::calc_status_s                      calc_status_o,
    output logic                                        wb_valid_o,
    output calc_pkg::reg_addr_t                         wb_rd_addr_o
  );

  calc_pkg::stage_info_s                          stage_isd;
  calc_pkg::stage_info_s [calc_pkg::stage_els:0]   stage_n;
  calc_pkg::stage_info_s [calc_pkg::stage_els-1:0] stage_r;
  logic                  [calc_pkg::stage_els:0]   poison_n;
  logic                  [calc_pkg::stage_els-1:0] poison_r;

  // Decode what the later stages need from the dispatched instruction
  always_comb
  begin
    stage_isd.v          = dispatch_pkt_i.v;
    stage_isd.opcode     = dispatch_pkt_i.opcode;
    stage_isd.rd_addr    = dispatch_pkt_i.rd_addr;
    stage_isd.irf_w_v    = dispatch_pkt_i.v & (dispatch_pkt_i.rd_addr != '0);
    stage_isd.pipe_mul_v = (dispatch_pkt_i.opcode == calc_pkg::e_op_mul);
  end

  assign stage_n = {stage_r, stage_isd};

  // Flush kills everything not yet at the writeback stage
  always_comb
  begin
    poison_n[0] = flush_i;
    for (int i = 1; i <= calc_pkg::stage_els; i++)
    begin
      if (i < calc_pkg::stage_els)
      begin
        poison_n[i] = poison_r[i-1] | flush_i;
      end
      else
      begin
        poison_n[i] = poison_r[i-1];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stage_r  <= '0;
      poison_r <= '0;
    end
    else
    begin
      stage_r  <= stage_n[calc_pkg::stage_els-1:0];
      poison_r <= poison_n[calc_pkg::stage_els-1:0];
    end
  end

  // Pipe completion strobes for the result injection points
  assign int_done_o = stage_r[0].v & (stage_r[0].opcode != calc_pkg::e_op_mul);
  assign mul_done_o = stage_r[calc_pkg::mul_inject_stage-1].v
                    & stage_r[calc_pkg::mul_inject_stage-1].pipe_mul_v;

  always_comb
  begin
    for (int i = 1; i <= calc_pkg::stage_els; i++)
    begin
      fwd_o[i].iwb_v   = stage_n[i].irf_w_v & ~poison_n[i];
      fwd_o[i].rd_addr = stage_n[i].rd_addr;
    end
  end

  // Issue checker status takes poison from the stage being entered
  always_comb
  begin
    for (int i = 0; i < calc_pkg::stage_els; i++)
    begin
      calc_status_o[i].v         = stage_r[i].v;
      calc_status_o[i].int_iwb_v = ~stage_r[i].pipe_mul_v & stage_r[i].irf_w_v
                                 & ~poison_n[i+1];
      calc_status_o[i].mul_iwb_v = stage_r[i].pipe_mul_v & stage_r[i].irf_w_v
                                 & ~poison_n[i+1];
      calc_status_o[i].rd_addr   = stage_r[i].rd_addr;
    end
  end

  assign wb_valid_o   = stage_r[calc_pkg::stage_els-1].irf_w_v
                      & ~poison_r[calc_pkg::stage_els-1];
  assign wb_rd_addr_o = stage_r[calc_pkg::stage_els-1].rd_addr;

endmodule

/* design/calc_top.sv */
`timescale 1ns/1ps

module calc_top
  (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  calc_pkg::dispatch_pkt_s dispatch_pkt_i,
    input  logic                   flush_i,
    output calc_pkg::calc_status_s  calc_status_o,
    output calc_pkg::wb_pkt_s       wb_pkt_o
  );

  calc_pkg::fwd_slice_s [calc_pkg::stage_els:1] fwd;
  calc_pkg::data_t      [calc_pkg::stage_els:1] fwd_data;
  calc_pkg::dispatch_pkt_s                      reservation;

  calc_pkg::data_t     int_data;
  calc_pkg::data_t     mul_data;
  logic                int_done;
  logic                mul_done;
  logic                wb_valid;
  calc_pkg::reg_addr_t wb_rd_addr;
  calc_pkg::data_t     wb_data;

  calc_ctrl calc_ctrl_i
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .dispatch_pkt_i (dispatch_pkt_i),
      .flush_i        (flush_i),
      .fwd_o          (fwd),
      .int_done_o     (int_done),
      .mul_done_o     (mul_done),
      .calc_status_o  (calc_status_o),
      .wb_valid_o     (wb_valid),
      .wb_rd_addr_o   (wb_rd_addr)
    );

  calc_operand_stage calc_operand_stage_i
    (
      .clk_i          (clk_i),
      .dispatch_pkt_i (dispatch_pkt_i),
      .fwd_i          (fwd),
      .fwd_data_i     (fwd_data),
      .reservation_o  (reservation)
    );

  calc_pipe_int calc_pipe_int_i
    (
      .reservation_i (reservation),
      .data_o        (int_data)
    );

  calc_pipe_mul calc_pipe_mul_i
    (
      .clk_i         (clk_i),
      .reservation_i (reservation),
      .data_o        (mul_data)
    );

  calc_completion calc_completion_i
    (
      .clk_i      (clk_i),
      .int_data_i (int_data),
      .mul_data_i (mul_data),
      .int_done_i (int_done),
      .mul_done_i (mul_done),
      .fwd_data_o (fwd_data),
      .wb_data_o  (wb_data)
    );

  assign wb_pkt_o = '{rd_w_v: wb_valid, rd_addr: wb_rd_addr, rd_data: wb_data};

endmodule

/* test/calc_chk.sv */
`timescale 1ns/1ps

module calc_chk
  (
    input logic              clk_i,
    input logic              reset_i,
    input logic              flush_i,
    input calc_pkg::wb_pkt_s wb_pkt_i
  );

  // Register x0 is never written
  wb_no_x0: assert property (@(posedge clk_i)
    wb_pkt_i.rd_w_v |-> (wb_pkt_i.rd_addr != '0))
    else $error("rd_w_v set with rd_addr x0");

  // Reset clears the writeback stage
  wb_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !wb_pkt_i.rd_w_v)
    else $error("rd_w_v set in the cycle after reset");

  // Instruction one step from writeback is poisoned by a flush
  wb_after_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !wb_pkt_i.rd_w_v)
    else $error("rd_w_v set in the cycle after flush");

endmodule

bind calc_top calc_chk calc_chk_i
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (flush_i),
    .wb_pkt_i (wb_pkt_o)
  );

/* test/calc_tb.sv */
`timescale 1ns/1ps

module calc_tb;

  localparam int clk_period      = 100;
  localparam int reset_cycles    = 10;
  localparam int fields_per_line = 12;
  localparam int max_lines       = 64;

  logic                    clk_i;
  logic                    reset_i;
  calc_pkg::dispatch_pkt_s dispatch_pkt_i;
  logic                    flush_i;
  calc_pkg::calc_status_s  calc_status_o;
  calc_pkg::wb_pkt_s       wb_pkt_o;

  logic [31:0] test_mem [0:fields_per_line*max_lines-1];
  int          num_lines;
  int          check_count;
  int          error_count;
  logic        loaded;

  calc_top calc_top_i
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .dispatch_pkt_i (dispatch_pkt_i),
      .flush_i        (flush_i),
      .calc_status_o  (calc_status_o),
      .wb_pkt_o       (wb_pkt_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(clk_period/2) clk_i = ~clk_i;
    end
  end

  // First eight fields of a line are the stimulus for that cycle
  task automatic drive_stimulus(input int idx);
    int base;
    base = idx * fields_per_line;
    dispatch_pkt_i.v        = test_mem[base][0];
    dispatch_pkt_i.opcode   = calc_pkg::op_e'(test_mem[base+1][3:0]);
    dispatch_pkt_i.rd_addr  = test_mem[base+2][4:0];
    dispatch_pkt_i.rs1_addr = test_mem[base+3][4:0];
    dispatch_pkt_i.rs2_addr = test_mem[base+4][4:0];
    dispatch_pkt_i.rs1      = test_mem[base+5];
    dispatch_pkt_i.rs2      = test_mem[base+6];
    flush_i                 = test_mem[base+7][0];
  endtask

  // Writeback address and data only matter when a write is expected
  task automatic check_outputs(input int idx);
    int                     base;
    logic                   exp_w;
    calc_pkg::reg_addr_t    exp_rd;
    calc_pkg::data_t        exp_data;
    calc_pkg::calc_status_s exp_status;
    base       = idx * fields_per_line + 8;
    exp_w      = test_mem[base][0];
    exp_rd     = test_mem[base+1][4:0];
    exp_data   = test_mem[base+2];
    exp_status = test_mem[base+3];
    check_count++;
    if (wb_pkt_o.rd_w_v !== exp_w)
    begin
      error_count++;
      $display("ERR line %0d wb_pkt_o.rd_w_v expected %h actual %h",
               idx, exp_w, wb_pkt_o.rd_w_v);
    end
    if (exp_w && (wb_pkt_o.rd_addr !== exp_rd))
    begin
      error_count++;
      $display("ERR line %0d wb_pkt_o.rd_addr expected %h actual %h",
               idx, exp_rd, wb_pkt_o.rd_addr);
    end
    if (exp_w && (wb_pkt_o.rd_data !== exp_data))
    begin
      error_count++;
      $display("ERR line %0d wb_pkt_o.rd_data expected %h actual %h",
               idx, exp_data, wb_pkt_o.rd_data);
    end
    if (calc_status_o !== exp_status)
    begin
      error_count++;
      $display("ERR line %0d calc_status_o expected %h actual %h",
               idx, exp_status, calc_status_o);
    end
  endtask

  initial
  begin
    reset_i        = 1'b1;
    flush_i        = 1'b0;
    dispatch_pkt_i = '0;
    num_lines      = 0;
    check_count    = 0;
    error_count    = 0;
    loaded         = 1'b0;
    $readmemh("test/calc_tests.txt", test_mem);
    while ((num_lines < max_lines) && !$isunknown(test_mem[num_lines*fields_per_line]))
    begin
      num_lines++;
    end
    loaded = 1'b1;
    if (num_lines == 0)
    begin
      error_count++;
      $display("No test lines could be read from test/calc_tests.txt");
    end
    repeat (reset_cycles) @(posedge clk_i);
    // Drive shortly after the edge, check just before the next one
    for (int i = 0; i < num_lines; i++)
    begin
      #5;
      reset_i = 1'b0;
      drive_stimulus(i);
      #(clk_period - 10);
      check_outputs(i);
      @(posedge clk_i);
    end
    $display("Cycles checked: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the number of test lines
  initial
  begin
    wait (loaded === 1'b1);
    #((num_lines + 20) * clk_period);
    $display("Timeout: the run did not finish within %0d cycles", num_lines + 20);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* calc.f */
design/calc_pkg.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_completion.sv
design/calc_operand_stage.sv
design/calc_ctrl.sv
design/calc_top.sv
test/calc_chk.sv
test/calc_tb.sv

/* Bender.yml */
package:
  name: calc

sources:
  - design/calc_pkg.sv
  - design/calc_pipe_int.sv
  - design/calc_pipe_mul.sv
  - design/calc_completion.sv
  - design/calc_operand_stage.sv
  - design/calc_ctrl.sv
  - design/calc_top.sv
  - target: test
    files:
      - test/calc_chk.sv
      - test/calc_tb.sv

/* test/calc_tests.txt */
// v op rd rs1_addr rs2_addr rs1 rs2 flush  rd_w_v rd_addr rd_data calc_status
// One line per cycle in hex, rd_addr and rd_data are compared only when rd_w_v is 1
0 0 00 00 00 00000000 00000000 0  0 00 00000000 00000000
0 0 00 00 00 00000000 00000000 0  0 00 00000000 00000000
1 0 0a 01 02 00001234 00004321 0  0 00 00000000 00000000
1 1 0b 01 02 00001000 00002000 0  0 00 00000000 000000ca
1 2 0c 01 02 f0f0f0f0 ff00ff00 0  0 00 00000000 0000cacb
1 3 0d 01 02 12340000 00005678 0  0 00 00000000 00cacbcc
1 4 0e 01 02 aaaa5555 ffff0000 0  1 0a 00005555 cacbcccd
1 5 0f 01 02 00000001 00000024 0  1 0b fffff000 cbcccdce
1 6 10 01 02 80000000 0000001f 0  1 0c f000f000 cccdcecf
1 7 11 01 02 ffffffff 00000001 0  1 0d 12345678 cdcecfd0
1 7 12 01 02 00000005 fffffffe 0  1 0e 55555555 cecfd0d1
1 0 00 01 02 11111111 22222222 0  1 0f 00000010 cfd0d1d2
1 8 13 01 02 00000007 00000006 0  1 10 00000001 d0d1d280
1 8 14 01 02 00012345 00000100 0  1 11 00000001 d1d280b3
1 8 15 01 02 ffffffff 00000003 0  1 12 00000000 d280b3b4
1 8 16 01 02 0000ffff 0000ffff 0  0 00 00000000 80b3b4b5
1 0 18 1e 1f 00000100 00000023 0  1 13 0000002a b3b4b5b6
1 0 19 18 1f dead0000 00000001 0  1 14 01234500 b4b5b6d8
1 0 1a 1e 18 00000010 dead0000 0  1 15 fffffffd b5b6d8d9
1 1 1b 18 19 dead0000 dead0000 0  1 16 fffe0001 b6d8d9da
1 3 1c 18 1e dead0000 00010000 0  1 18 00000123 d8d9dadb
1 0 1d 1e 1f 00000001 00000002 0  1 19 00000124 d9dadbdc
1 0 1d 1e 1f 00000100 00000200 0  1 1a 00000133 dadbdcdd
1 4 17 1d 1e dead0000 0000ffff 0  1 1b ffffffff dbdcdddd
1 0 05 1e 1f 00000001 00000001 0  1 1c 00010123 dcddddd7
1 0 06 1e 1f 00000002 00000002 0  1 1d 00000003 ddddd7c5
1 8 07 1e 1f 00000003 00000003 0  1 1d 00000300 ddd7c5c6
1 2 08 1e 1f 000000ff 0000000f 0  1 17 0000fcff d7c5c6a7
1 3 09 1e 1f 00000010 00000001 1  1 05 00000002 c5868788
1 0 06 1e 1f 00000040 00000002 0  0 00 00000000 86878889
0 0 00 00 00 00000000 00000000 0  0 00 00000000 878889c6
0 0 00 00 00 00000000 00000000 0  0 00 00000000 8889c600
0 0 00 00 00 00000000 00000000 0  0 00 00000000 89c60000
0 0 00 00 00 00000000 00000000 0  1 06 00000042 c6000000
